//--- snake_pkg.sv
// Shared types, opcodes and UART timing constants for the snake game serial link.
`default_nettype none

package snake_pkg;

    // Snake move carried in a direction message.
    typedef enum logic [2:0] {
        NONE,
        UP,
        DOWN,
        LEFT,
        RIGHT
    } direction;

    typedef logic [4:0] coord_t;   // Seed coordinate.
    typedef logic [7:0] byte_t;    // One UART data byte.
    typedef logic [1:0] opcode_t;  // Message opcode, top two bits of a byte.

    localparam opcode_t OP_DIR    = 2'd0;
    localparam opcode_t OP_SEED_X = 2'd1;
    localparam opcode_t OP_SEED_Y = 2'd2;

    localparam int CLKS_PER_BIT = 16;
    localparam int FIFO_DEPTH   = 4;

    localparam int CNT_W  = $clog2(CLKS_PER_BIT);
    localparam int PTR_W  = $clog2(FIFO_DEPTH);
    localparam int OCC_W  = $clog2(FIFO_DEPTH + 1);

    typedef logic [CNT_W-1:0] clk_cnt_t;   // Clocks within one serial bit.
    typedef logic [2:0]       bit_idx_t;   // Data bit index within a frame.
    typedef logic [PTR_W-1:0] fifo_ptr_t;
    typedef logic [OCC_W-1:0] fifo_cnt_t;

    // Frame phases, shared by receiver and transmitter.
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_START,
        ST_DATA,
        ST_STOP
    } uart_state_t;

endpackage

`default_nettype wire

//--- uart_rx.sv
// UART receiver, 8N1, samples mid-bit and pulses rx_done once per received byte.
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
    input  logic              clk,
    input  logic              rst,
    input  logic              rx,
    output snake_pkg::byte_t  rx_data,
    output logic              rx_done
);

    logic                   rx_meta;
    logic                   rx_sync;
    snake_pkg::uart_state_t state;
    snake_pkg::clk_cnt_t    clk_cnt;
    snake_pkg::bit_idx_t    bit_idx;

    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta <= 1'b1;  // Line idles high.
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= snake_pkg::ST_IDLE;
            clk_cnt <= '0;
            bit_idx <= '0;
            rx_done <= 1'b0;
        end else begin
            rx_done <= 1'b0;
            case (state)
                snake_pkg::ST_IDLE: begin
                    clk_cnt <= '0;
                    bit_idx <= '0;
                    if (!rx_sync) begin
                        state <= snake_pkg::ST_START;
                    end
                end
                snake_pkg::ST_START: begin
                    if (clk_cnt == snake_pkg::clk_cnt_t'(snake_pkg::CLKS_PER_BIT / 2 - 1)) begin
                        clk_cnt <= '0;
                        // A start bit that is high again by now was a glitch.
                        state   <= rx_sync ? snake_pkg::ST_IDLE : snake_pkg::ST_DATA;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                snake_pkg::ST_DATA: begin
                    if (clk_cnt == snake_pkg::clk_cnt_t'(snake_pkg::CLKS_PER_BIT - 1)) begin
                        clk_cnt <= '0;
                        if (bit_idx == 3'd7) begin
                            state <= snake_pkg::ST_STOP;
                        end
                        bit_idx <= bit_idx + 1'b1;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: begin
                    if (clk_cnt == snake_pkg::clk_cnt_t'(snake_pkg::CLKS_PER_BIT - 1)) begin
                        rx_done <= 1'b1;  // Middle of the stop bit.
                        state   <= snake_pkg::ST_IDLE;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // LSB arrives first, so bits enter at the top and move down.
    always_ff @(posedge clk) begin
        if (state == snake_pkg::ST_DATA &&
            clk_cnt == snake_pkg::clk_cnt_t'(snake_pkg::CLKS_PER_BIT - 1)) begin
            rx_data <= {rx_sync, rx_data[7:1]};
        end
    end

    a_done_single: assert property (@(posedge clk) disable iff (rst) rx_done |=> !rx_done);

endmodule

`default_nettype wire

//--- uart_tx.sv
// UART transmitter, 8N1, pulls bytes from the transmit FIFO and shifts them out LSB first.
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
    input  logic              clk,
    input  logic              rst,
    input  logic              fifo_empty,
    input  snake_pkg::byte_t  fifo_data,
    output logic              fifo_rd,
    output logic              tx
);

    snake_pkg::uart_state_t state;
    snake_pkg::clk_cnt_t    clk_cnt;
    snake_pkg::bit_idx_t    bit_idx;
    snake_pkg::byte_t       shreg;
    logic                   bit_end;

    assign fifo_rd = (state == snake_pkg::ST_IDLE) && !fifo_empty;
    assign bit_end = (clk_cnt == snake_pkg::clk_cnt_t'(snake_pkg::CLKS_PER_BIT - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= snake_pkg::ST_IDLE;
            clk_cnt <= '0;
            bit_idx <= '0;
            tx      <= 1'b1;
        end else begin
            clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
            case (state)
                snake_pkg::ST_IDLE: begin
                    clk_cnt <= '0;
                    bit_idx <= '0;
                    if (fifo_rd) begin
                        state <= snake_pkg::ST_START;
                        tx    <= 1'b0;  // Start bit.
                    end
                end
                snake_pkg::ST_START: begin
                    if (bit_end) begin
                        state <= snake_pkg::ST_DATA;
                        tx    <= shreg[0];
                    end
                end
                snake_pkg::ST_DATA: begin
                    if (bit_end) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= snake_pkg::ST_STOP;
                            tx    <= 1'b1;
                        end else begin
                            tx <= shreg[1];
                        end
                    end
                end
                default: begin
                    if (bit_end) begin
                        state <= snake_pkg::ST_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fifo_rd) begin
            shreg <= fifo_data;
        end else if (state == snake_pkg::ST_DATA && bit_end) begin
            shreg <= {1'b0, shreg[7:1]};
        end
    end

    a_idle_high: assert property (@(posedge clk) disable iff (rst)
        (state == snake_pkg::ST_IDLE) |-> tx);

endmodule

`default_nettype wire

//--- uart_fifo.sv
// Byte FIFO between the link logic and the UART, head entry shown on rd_data.
`timescale 1ns/1ps
`default_nettype none

module uart_fifo (
    input  logic              clk,
    input  logic              rst,
    input  logic              wr_en,
    input  snake_pkg::byte_t  wr_data,
    input  logic              rd_en,
    output snake_pkg::byte_t  rd_data,
    output logic              full,
    output logic              empty
);

    snake_pkg::byte_t     mem [snake_pkg::FIFO_DEPTH];
    snake_pkg::fifo_ptr_t wr_ptr;
    snake_pkg::fifo_ptr_t rd_ptr;
    snake_pkg::fifo_cnt_t count;
    logic                 wr_ok;
    logic                 rd_ok;

    assign full    = (count == snake_pkg::fifo_cnt_t'(snake_pkg::FIFO_DEPTH));
    assign empty   = (count == '0);
    assign wr_ok   = wr_en && !full;
    assign rd_ok   = rd_en && !empty;
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= (wr_ptr == snake_pkg::fifo_ptr_t'(snake_pkg::FIFO_DEPTH - 1)) ?
                          '0 : wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= (rd_ptr == snake_pkg::fifo_ptr_t'(snake_pkg::FIFO_DEPTH - 1)) ?
                          '0 : rd_ptr + 1'b1;
            end
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Both or neither.
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    a_no_overflow:  assert property (@(posedge clk) disable iff (rst) wr_en |-> !full);
    a_no_underflow: assert property (@(posedge clk) disable iff (rst) rd_en |-> !empty);

endmodule

`default_nettype wire

//--- game_link.sv
// Top of the board-to-board link; encodes direction and seed messages and decodes received ones.
`timescale 1ns/1ps
`default_nettype none

module game_link (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rx,
    input  logic                 send,
    input  logic                 seed_rdy,
    input  snake_pkg::coord_t    seed_x_in,
    input  snake_pkg::coord_t    seed_y_in,
    input  snake_pkg::direction  dir1,
    output logic                 tx,
    output logic                 start_game,
    output snake_pkg::coord_t    seed_x_out,
    output snake_pkg::coord_t    seed_y_out,
    output snake_pkg::direction  dir2,
    output logic                 rcvdir
);

    snake_pkg::byte_t     rx_data;
    logic                 rx_done;
    snake_pkg::byte_t     rx_fifo_data;
    logic                 rx_full;
    logic                 rx_empty;
    logic                 rx_rd;
    snake_pkg::byte_t     rx_byte_q;
    logic                 rx_valid_q;
    snake_pkg::opcode_t   rx_op;

    logic                 tx_wr;
    snake_pkg::byte_t     tx_wr_data;
    logic                 tx_full;
    logic                 tx_empty;
    snake_pkg::byte_t     tx_fifo_data;
    logic                 tx_rd;

    logic                 send_prv;
    logic                 dir_pend;
    logic                 seed_x_pend;
    logic                 seed_y_pend;
    snake_pkg::direction  dir_q;
    snake_pkg::coord_t    seed_x_q;
    snake_pkg::coord_t    seed_y_q;

    uart_rx u_uart_rx (
        .clk     (clk),
        .rst     (rst),
        .rx      (rx),
        .rx_data (rx_data),
        .rx_done (rx_done)
    );

    uart_fifo u_rx_fifo (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (rx_done && !rx_full),
        .wr_data (rx_data),
        .rd_en   (rx_rd),
        .rd_data (rx_fifo_data),
        .full    (rx_full),
        .empty   (rx_empty)
    );

    uart_fifo u_tx_fifo (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (tx_wr),
        .wr_data (tx_wr_data),
        .rd_en   (tx_rd),
        .rd_data (tx_fifo_data),
        .full    (tx_full),
        .empty   (tx_empty)
    );

    uart_tx u_uart_tx (
        .clk        (clk),
        .rst        (rst),
        .fifo_empty (tx_empty),
        .fifo_data  (tx_fifo_data),
        .fifo_rd    (tx_rd),
        .tx         (tx)
    );

    // Receive side. At most one byte every other cycle, so rcvdir stays a pulse.
    assign rx_rd = !rx_empty && !rx_valid_q;
    assign rx_op = rx_byte_q[7:6];

    always_ff @(posedge clk) begin
        if (rst) begin
            rx_valid_q <= 1'b0;
        end else begin
            rx_valid_q <= rx_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (rx_rd) begin
            rx_byte_q <= rx_fifo_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dir2       <= snake_pkg::NONE;
            rcvdir     <= 1'b0;
            start_game <= 1'b0;
            seed_x_out <= '0;
            seed_y_out <= '0;
        end else begin
            rcvdir <= 1'b0;
            if (rx_valid_q) begin
                case (rx_op)
                    snake_pkg::OP_DIR: begin
                        dir2   <= snake_pkg::direction'(rx_byte_q[2:0]);
                        rcvdir <= 1'b1;
                    end
                    snake_pkg::OP_SEED_X: begin
                        seed_x_out <= rx_byte_q[4:0];
                        start_game <= 1'b0;  // New game setup begins.
                    end
                    snake_pkg::OP_SEED_Y: begin
                        seed_y_out <= rx_byte_q[4:0];
                        start_game <= 1'b1;
                    end
                    default: ;  // Opcode three is dropped.
                endcase
            end
        end
    end

    // Transmit side. Seed x first, then seed y, then a direction.
    always_comb begin
        tx_wr      = 1'b0;
        tx_wr_data = '0;
        if (!tx_full) begin
            if (seed_x_pend) begin
                tx_wr      = 1'b1;
                tx_wr_data = {snake_pkg::OP_SEED_X, 1'b0, seed_x_q};
            end else if (seed_y_pend) begin
                tx_wr      = 1'b1;
                tx_wr_data = {snake_pkg::OP_SEED_Y, 1'b0, seed_y_q};
            end else if (dir_pend) begin
                tx_wr      = 1'b1;
                tx_wr_data = {snake_pkg::OP_DIR, 3'b000, dir_q};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            send_prv    <= 1'b0;
            dir_pend    <= 1'b0;
            seed_x_pend <= 1'b0;
            seed_y_pend <= 1'b0;
        end else begin
            send_prv <= send;
            if (seed_rdy) begin
                seed_x_pend <= 1'b1;
                seed_y_pend <= 1'b0;
            end else if (tx_wr && seed_x_pend) begin
                seed_x_pend <= 1'b0;
                seed_y_pend <= 1'b1;  // Y follows on the next free cycle.
            end else if (tx_wr && seed_y_pend) begin
                seed_y_pend <= 1'b0;
            end
            if (send && !send_prv) begin
                dir_pend <= 1'b1;
            end else if (tx_full) begin
                dir_pend <= 1'b0;  // Dropped under back-pressure.
            end else if (tx_wr && !seed_x_pend && !seed_y_pend) begin
                dir_pend <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (seed_rdy) begin
            seed_x_q <= seed_x_in;
            seed_y_q <= seed_y_in;
        end
        if (send && !send_prv) begin
            dir_q <= dir1;
        end
    end

    a_rx_no_drop:   assert property (@(posedge clk) disable iff (rst) rx_done |-> !rx_full);
    a_rcvdir_pulse: assert property (@(posedge clk) disable iff (rst) rcvdir |=> !rcvdir);

endmodule

`default_nettype wire

//--- tb_checker.sv
// Testbench checker for game_link; decodes both serial lines and compares against reference rules.
`timescale 1ns/1ps
`default_nettype none

// Recovers one 8N1 frame from a serial line, pulsing valid at the end of the stop bit.
module frame_decoder (
    input  logic             clk,
    input  logic             rst,
    input  logic             line,
    output snake_pkg::byte_t data,
    output logic             stop_ok,
    output logic             valid,
    output logic             active
);

    localparam int BIT = snake_pkg::CLKS_PER_BIT;

    int cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
            valid  <= 1'b0;
            cnt    <= 0;
        end else begin
            valid <= 1'b0;
            if (!active) begin
                if (!line) begin
                    active <= 1'b1;
                    cnt    <= 1;
                end
            end else begin
                cnt <= cnt + 1;
                if (cnt % BIT == BIT / 2 - 1 && cnt > BIT && cnt < 9 * BIT) begin
                    data <= {line, data[7:1]};  // Mid-bit sample, LSB first.
                end
                if (cnt == 9 * BIT + BIT / 2 - 1) begin
                    stop_ok <= line;
                end
                if (cnt == 10 * BIT - 1) begin
                    valid  <= 1'b1;
                    active <= 1'b0;
                end
            end
        end
    end

endmodule

module tb_checker (
    input  logic                clk,
    input  logic                rst,
    input  logic                rx,
    input  logic                tx,
    input  logic                send,
    input  logic                seed_rdy,
    input  snake_pkg::coord_t   seed_x_in,
    input  snake_pkg::coord_t   seed_y_in,
    input  snake_pkg::direction dir1,
    input  snake_pkg::direction dir2,
    input  snake_pkg::coord_t   seed_x_out,
    input  snake_pkg::coord_t   seed_y_out,
    input  logic                start_game,
    input  logic                rcvdir,
    input  int                  test_num,
    input  logic                test_end,
    input  logic                all_done,
    output logic                busy,
    output int                  errors,
    output logic                report_done
);

    localparam int RX_WINDOW = 3;  // Cycles allowed after the stop bit ends.

    snake_pkg::byte_t exp_q[$];
    snake_pkg::byte_t exp_byte;
    snake_pkg::byte_t tx_data;
    snake_pkg::byte_t rx_data;
    logic             tx_valid;
    logic             tx_stop_ok;
    logic             tx_active;
    logic             rx_valid;
    logic             rx_active;
    logic             send_seen;
    logic [13:0]      link_state;  // {start_game, seed y, seed x, dir2}.
    logic [14:0]      rx_expect;   // Expected rcvdir pulse on top of link_state.
    int               checks;
    int               pulses;
    int               win;
    int               err_base;
    int               chk_base;

    frame_decoder u_tx_decoder (
        .clk     (clk),
        .rst     (rst),
        .line    (tx),
        .data    (tx_data),
        .stop_ok (tx_stop_ok),
        .valid   (tx_valid),
        .active  (tx_active)
    );

    frame_decoder u_rx_decoder (
        .clk     (clk),
        .rst     (rst),
        .line    (rx),
        .data    (rx_data),
        .stop_ok (),
        .valid   (rx_valid),
        .active  (rx_active)
    );

    // Opcode in the top two bits, payload below.
    function automatic snake_pkg::byte_t tx_expect(input snake_pkg::opcode_t op,
                                                   input logic [4:0] payload);
        return {op, 1'b0, payload};
    endfunction

    function automatic logic [14:0] rx_effect(input logic [13:0] cur, input snake_pkg::byte_t b);
        logic [14:0] nxt;
        nxt = {1'b0, cur};
        case (b[7:6])
            snake_pkg::OP_DIR: begin
                nxt[2:0] = b[2:0];
                nxt[14]  = 1'b1;
            end
            snake_pkg::OP_SEED_X: begin
                nxt[7:3] = b[4:0];
                nxt[13]  = 1'b0;
            end
            snake_pkg::OP_SEED_Y: begin
                nxt[12:8] = b[4:0];
                nxt[13]   = 1'b1;
            end
            default: ;
        endcase
        return nxt;
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            exp_q.delete();
            link_state = '0;
            pulses     = 0;
            win        = 0;
            checks     = 0;
            errors     = 0;
            err_base   = 0;
            chk_base   = 0;
            send_seen   <= 1'b0;
            busy        <= 1'b0;
            report_done <= 1'b0;
        end else begin
            if (rcvdir) begin
                pulses = pulses + 1;
            end
            // Seeds requested on the same edge as a direction go out first.
            if (seed_rdy) begin
                exp_q.push_back(tx_expect(snake_pkg::OP_SEED_X, seed_x_in));
                exp_q.push_back(tx_expect(snake_pkg::OP_SEED_Y, seed_y_in));
            end
            if (send && !send_seen) begin
                exp_q.push_back(tx_expect(snake_pkg::OP_DIR, {2'b00, dir1}));
            end
            send_seen <= send;

            if (tx_valid) begin
                if (exp_q.size() == 0) begin
                    errors = errors + 1;
                    $display("error at %0t: tx sent byte %h with no request pending",
                             $time, tx_data);
                end else begin
                    exp_byte = exp_q.pop_front();
                    if (tx_data !== exp_byte || !tx_stop_ok) begin
                        errors = errors + 1;
                        $display("error at %0t: tx byte %h stop %b, expected %h",
                                 $time, tx_data, tx_stop_ok, exp_byte);
                    end else begin
                        checks = checks + 1;
                    end
                end
            end

            if (rx_valid) begin
                rx_expect = rx_effect(link_state, rx_data);
                win       = RX_WINDOW + 1;
            end
            if (win > 0) begin
                if ({start_game, seed_y_out, seed_x_out, dir2} == rx_expect[13:0] &&
                    pulses == int'(rx_expect[14])) begin
                    checks     = checks + 1;
                    link_state = rx_expect[13:0];
                    pulses     = 0;
                    win        = 0;
                end else if (win == 1) begin
                    errors = errors + 1;
                    $display("error at %0t: rx byte %h gave %h with %0d rcvdir, expected %h",
                             $time, rx_data, {start_game, seed_y_out, seed_x_out, dir2},
                             pulses, rx_expect);
                    link_state = rx_expect[13:0];
                    pulses     = 0;
                    win        = 0;
                end else begin
                    win = win - 1;
                end
            end

            if (test_end) begin
                $display("test %0d %s: %0d checks, %0d errors", test_num,
                         (errors == err_base) ? "passed" : "failed",
                         checks - chk_base, errors - err_base);
                err_base = errors;
                chk_base = checks;
            end

            if (all_done && !report_done) begin
                if (exp_q.size() != 0) begin
                    errors = errors + 1;
                    $display("%0d requested tx bytes were never sent", exp_q.size());
                end
                if (pulses != 0) begin
                    errors = errors + 1;
                    $display("rcvdir pulsed without a received direction byte");
                end
                $display("closing count: %0d checks, %0d errors", checks, errors);
                report_done <= 1'b1;
            end

            busy <= (exp_q.size() != 0) || tx_active || rx_active || (win > 0);
        end
    end

endmodule

`default_nettype wire

//--- tb_game_link.sv
// Testbench top for game_link; plays the peer board and sequences the directed and random tests.
`timescale 1ns/1ps
`default_nettype none

module tb_game_link;

    localparam int FRAME_CYCLES   = 10 * snake_pkg::CLKS_PER_BIT;
    localparam int MAX_FRAMES     = 30;
    localparam int TIMEOUT_CYCLES = MAX_FRAMES * FRAME_CYCLES * 4;  // Ample margin.
    localparam int RANDOM_ROUNDS  = 10;

    logic                clk;
    logic                rst;
    logic                rx;
    logic                send;
    logic                seed_rdy;
    snake_pkg::coord_t   seed_x_in;
    snake_pkg::coord_t   seed_y_in;
    snake_pkg::direction dir1;
    logic                tx;
    logic                start_game;
    snake_pkg::coord_t   seed_x_out;
    snake_pkg::coord_t   seed_y_out;
    snake_pkg::direction dir2;
    logic                rcvdir;
    int                  test_num;
    logic                test_end;
    logic                all_done;
    logic                busy;
    logic                report_done;
    int                  errors;
    int                  seed = 10;
    int                  cycles;

    game_link u_game_link (
        .clk        (clk),
        .rst        (rst),
        .rx         (rx),
        .send       (send),
        .seed_rdy   (seed_rdy),
        .seed_x_in  (seed_x_in),
        .seed_y_in  (seed_y_in),
        .dir1       (dir1),
        .tx         (tx),
        .start_game (start_game),
        .seed_x_out (seed_x_out),
        .seed_y_out (seed_y_out),
        .dir2       (dir2),
        .rcvdir     (rcvdir)
    );

    tb_checker u_checker (
        .clk         (clk),
        .rst         (rst),
        .rx          (rx),
        .tx          (tx),
        .send        (send),
        .seed_rdy    (seed_rdy),
        .seed_x_in   (seed_x_in),
        .seed_y_in   (seed_y_in),
        .dir1        (dir1),
        .dir2        (dir2),
        .seed_x_out  (seed_x_out),
        .seed_y_out  (seed_y_out),
        .start_game  (start_game),
        .rcvdir      (rcvdir),
        .test_num    (test_num),
        .test_end    (test_end),
        .all_done    (all_done),
        .busy        (busy),
        .errors      (errors),
        .report_done (report_done)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // Peer board: one 8N1 frame, then a short idle gap.
    task automatic peer_byte(input snake_pkg::byte_t b);
        int i;
        rx <= 1'b0;
        repeat (snake_pkg::CLKS_PER_BIT) @(posedge clk);
        for (i = 0; i < 8; i++) begin
            rx <= b[i];
            repeat (snake_pkg::CLKS_PER_BIT) @(posedge clk);
        end
        rx <= 1'b1;
        repeat (2 * snake_pkg::CLKS_PER_BIT) @(posedge clk);
    endtask

    task automatic request_dir(input snake_pkg::direction d);
        dir1 <= d;
        send <= 1'b1;
        repeat (2) @(posedge clk);
        send <= 1'b0;
        @(posedge clk);
    endtask

    task automatic request_seeds(input snake_pkg::coord_t x, input snake_pkg::coord_t y);
        seed_x_in <= x;
        seed_y_in <= y;
        seed_rdy  <= 1'b1;
        @(posedge clk);
        seed_rdy  <= 1'b0;
        seed_x_in <= ~x;  // Only the values at the pulse count.
        seed_y_in <= ~y;
    endtask

    task automatic wait_idle();
        repeat (4) @(posedge clk);
        while (busy) @(posedge clk);
    endtask

    task automatic finish_test();
        wait_idle();
        test_end <= 1'b1;
        @(posedge clk);
        test_end <= 1'b0;
        test_num <= test_num + 1;
    endtask

    initial begin
        int r;
        rst       = 1'b1;
        rx        = 1'b1;
        send      = 1'b0;
        seed_rdy  = 1'b0;
        seed_x_in = '0;
        seed_y_in = '0;
        dir1      = snake_pkg::NONE;
        test_num  = 1;
        test_end  = 1'b0;
        all_done  = 1'b0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        repeat (2) @(posedge clk);

        peer_byte({snake_pkg::OP_DIR, 3'b000, snake_pkg::RIGHT});
        peer_byte({snake_pkg::OP_DIR, 3'b000, snake_pkg::UP});
        finish_test();

        peer_byte({snake_pkg::OP_SEED_X, 6'd17});
        peer_byte({snake_pkg::OP_SEED_Y, 6'd9});
        peer_byte({snake_pkg::OP_SEED_X, 6'd3});  // Clears start_game again.
        finish_test();

        peer_byte(8'hc5);
        finish_test();

        dir1 <= snake_pkg::LEFT;
        send <= 1'b1;
        @(posedge clk);
        dir1 <= snake_pkg::DOWN;
        repeat (2 * FRAME_CYCLES) @(posedge clk);
        send <= 1'b0;
        @(posedge clk);
        finish_test();

        request_seeds(5'd21, 5'd6);
        repeat (3) @(posedge clk);
        request_dir(snake_pkg::UP);
        finish_test();

        // At most three bytes queued per round, below the FIFO depth.
        for (r = 0; r < RANDOM_ROUNDS; r++) begin
            if (rand_below(2) == 1) begin
                request_seeds(snake_pkg::coord_t'(rand_below(32)),
                              snake_pkg::coord_t'(rand_below(32)));
            end
            if (rand_below(2) == 1) begin
                request_dir(snake_pkg::direction'(3'(rand_below(5))));
            end
            if (rand_below(4) == 0) begin
                peer_byte({snake_pkg::OP_DIR, 3'b000, 3'(rand_below(5))});
            end else begin
                peer_byte({2'(rand_below(3) + 1), 6'(rand_below(64))});
            end
            wait_idle();
        end
        finish_test();

        all_done <= 1'b1;
        @(posedge clk);
        while (!report_done) @(posedge clk);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        $display("timeout after %0d cycles, the link never went idle", cycles);
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
snake_pkg.sv
uart_rx.sv
uart_tx.sv
uart_fifo.sv
game_link.sv
tb_checker.sv
tb_game_link.sv

//--- run.sh
#!/bin/sh
# Build and run the game_link testbench with Verilator.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f tb.f --top-module tb_game_link -o tb_game_link; then
    echo "Verilator build failed"
    exit 1
fi

if ! out=$(./obj_dir/tb_game_link); then
    printf '%s\n' "$out"
    echo "Simulation exited with an error status"
    exit 1
fi

printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Finished with no errors"; then
    exit 0
fi
exit 1
